/* logic/conv_pkg.sv */
package conv_pkg;

	// Data widths.
	localparam int pixel_w = 16;
	localparam int coef_w = 16;
	// 54 products of 32 bits plus a bias need 38 bits.
	localparam int acc_w = 40;

	// Layer geometry.
	localparam int num_chan = 6;
	localparam int num_filt = 8;
	localparam int kern_dim = 3;
	localparam int kern_taps = kern_dim * kern_dim;

	// Select widths for the coefficient write port.
	localparam int filt_sel_w = $clog2(num_filt);
	localparam int chan_sel_w = $clog2(num_chan);
	localparam int tap_sel_w = $clog2(kern_taps);

	typedef logic signed [pixel_w-1:0] pixel_t;
	typedef logic signed [coef_w-1:0] coef_t;
	typedef logic signed [acc_w-1:0] acc_t;

	// One raster position, all channels.
	typedef pixel_t [num_chan-1:0] chan_pixels_t;

	// Tap = 3 * kernel row + kernel column, row 0 and column 0 oldest.
	typedef pixel_t [num_chan-1:0][kern_taps-1:0] window_t;

	typedef acc_t [num_filt-1:0] filt_acc_t;
	typedef pixel_t [num_filt-1:0] filt_pixels_t;

endpackage

/* logic/coef_if.sv */
interface coef_if;
	import conv_pkg::*;

	logic we;
	logic is_bias;
	logic [filt_sel_w-1:0] filt;
	logic [chan_sel_w-1:0] chan;
	logic [tap_sel_w-1:0] tap;
	coef_t data;

	modport src (
		output we, is_bias, filt, chan, tap, data
	);

	modport dst (
		input we, is_bias, filt, chan, tap, data
	);

endinterface

/* logic/window_decode.sv */
module window_decode #(
	parameter int img_width = 6,
	parameter int img_height = 6,
	parameter int stride = 1
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input conv_pkg::chan_pixels_t pix_in,
	output logic win_valid,
	output conv_pkg::window_t win
);
	import conv_pkg::*;

	localparam int col_w = (img_width > 1) ? $clog2(img_width) : 1;
	localparam int row_w = (img_height > 1) ? $clog2(img_height) : 1;
	localparam int last_row = kern_dim - 1;

	// Previous row and the one before it, by column.
	chan_pixels_t line_near [img_width];
	chan_pixels_t line_far [img_width];

	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	logic col_hit;
	logic row_hit;

	// Window is complete at its bottom right pixel, on the stride grid.
	assign col_hit = (col >= 2) && (((col - 2) % stride) == 0);
	assign row_hit = (row >= 2) && (((row - 2) % stride) == 0);

	always_ff @(posedge clk) begin
		if (valid_in) begin
			line_far[col] <= line_near[col];
			line_near[col] <= pix_in;
		end
	end

	// Columns move left, the new column enters at the right.
	always_ff @(posedge clk) begin
		if (valid_in) begin
			for (int ch = 0; ch < num_chan; ch++) begin
				for (int kr = 0; kr < kern_dim; kr++) begin
					for (int kc = 0; kc < kern_dim - 1; kc++) begin
						win[ch][kr*kern_dim+kc] <= win[ch][kr*kern_dim+kc+1];
					end
				end
				win[ch][kern_dim-1] <= line_far[col][ch];
				win[ch][2*kern_dim-1] <= line_near[col][ch];
				win[ch][last_row*kern_dim+kern_dim-1] <= pix_in[ch];
			end
		end
	end

	// Raster position of the next pixel.
	always_ff @(posedge clk) begin
		if (rst) begin
			row <= '0;
			col <= '0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= valid_in && row_hit && col_hit;
			if (valid_in) begin
				if (col == col_w'(img_width - 1)) begin
					col <= '0;
					if (row == row_w'(img_height - 1)) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule

/* logic/conv_mac.sv */
module conv_mac (
	input logic clk,
	input logic rst,
	coef_if.dst coef,
	input logic win_valid,
	input conv_pkg::window_t win,
	output logic acc_valid,
	output conv_pkg::filt_acc_t acc
);
	import conv_pkg::*;

	localparam int prod_w = pixel_w + coef_w;

	coef_t weight [num_filt][num_chan][kern_taps];
	coef_t bias [num_filt];

	logic signed [prod_w-1:0] prod [num_filt][num_chan][kern_taps];
	logic prod_valid;
	acc_t filt_sum [num_filt];

	// Coefficient store, loaded before streaming.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int f = 0; f < num_filt; f++) begin
				bias[f] <= '0;
				for (int c = 0; c < num_chan; c++) begin
					for (int t = 0; t < kern_taps; t++) begin
						weight[f][c][t] <= '0;
					end
				end
			end
		end else if (coef.we) begin
			if (coef.is_bias) begin
				bias[coef.filt] <= coef.data;
			end else if (coef.chan < num_chan && coef.tap < kern_taps) begin
				weight[coef.filt][coef.chan][coef.tap] <= coef.data;
			end
		end
	end

	// Stage one. Every tap times its weight, per filter.
	always_ff @(posedge clk) begin
		for (int f = 0; f < num_filt; f++) begin
			for (int c = 0; c < num_chan; c++) begin
				for (int t = 0; t < kern_taps; t++) begin
					prod[f][c][t] <= win[c][t] * weight[f][c][t];
				end
			end
		end
	end

	// Adder tree over 54 products, seeded with the bias.
	always_comb begin
		for (int f = 0; f < num_filt; f++) begin
			filt_sum[f] = acc_t'(bias[f]);
			for (int c = 0; c < num_chan; c++) begin
				for (int t = 0; t < kern_taps; t++) begin
					filt_sum[f] = filt_sum[f] + acc_t'(prod[f][c][t]);
				end
			end
		end
	end

	// Stage two.
	always_ff @(posedge clk) begin
		for (int f = 0; f < num_filt; f++) begin
			acc[f] <= filt_sum[f];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			acc_valid <= prod_valid;
		end
	end

endmodule

/* logic/result_stage.sv */
module result_stage #(
	parameter int relu_en = 1
) (
	input logic clk,
	input logic rst,
	input logic acc_valid,
	input conv_pkg::filt_acc_t acc,
	output logic valid_out,
	output conv_pkg::filt_pixels_t res_out
);
	import conv_pkg::*;

	// Pixel range in accumulator width.
	localparam acc_t pix_max = acc_t'(2 ** (pixel_w - 1) - 1);
	localparam acc_t pix_min = acc_t'(-(2 ** (pixel_w - 1)));

	acc_t clip [num_filt];
	filt_pixels_t res_next;

	always_comb begin
		for (int f = 0; f < num_filt; f++) begin
			clip[f] = acc[f];
			if (relu_en != 0 && clip[f] < 0) begin
				clip[f] = '0;
			end
			if (clip[f] > pix_max) begin
				clip[f] = pix_max;
			end else if (clip[f] < pix_min) begin
				clip[f] = pix_min;
			end
			res_next[f] = pixel_t'(clip[f]);
		end
	end

	// Results hold between windows.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out <= 1'b0;
			res_out <= '0;
		end else begin
			valid_out <= acc_valid;
			if (acc_valid) begin
				res_out <= res_next;
			end
		end
	end

endmodule

/* logic/conv_layer_top.sv */
module conv_layer_top #(
	parameter int img_width = 6,
	parameter int img_height = 6,
	parameter int stride = 1,
	parameter int relu_en = 1
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input conv_pkg::chan_pixels_t pix_in,
	input logic coef_we,
	input logic coef_is_bias,
	input logic [conv_pkg::filt_sel_w-1:0] coef_filt,
	input logic [conv_pkg::chan_sel_w-1:0] coef_chan,
	input logic [conv_pkg::tap_sel_w-1:0] coef_tap,
	input conv_pkg::coef_t coef_data,
	output logic valid_out,
	output conv_pkg::filt_pixels_t res_out
);
	import conv_pkg::*;

	logic win_valid;
	window_t win;
	logic acc_valid;
	filt_acc_t acc;

	coef_if coef_bus ();

	assign coef_bus.we = coef_we;
	assign coef_bus.is_bias = coef_is_bias;
	assign coef_bus.filt = coef_filt;
	assign coef_bus.chan = coef_chan;
	assign coef_bus.tap = coef_tap;
	assign coef_bus.data = coef_data;

	window_decode #(
		.img_width(img_width),
		.img_height(img_height),
		.stride(stride)
	) u_decode (
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.pix_in(pix_in),
		.win_valid(win_valid),
		.win(win)
	);

	conv_mac u_mac (
		.clk(clk),
		.rst(rst),
		.coef(coef_bus.dst),
		.win_valid(win_valid),
		.win(win),
		.acc_valid(acc_valid),
		.acc(acc)
	);

	result_stage #(
		.relu_en(relu_en)
	) u_result (
		.clk(clk),
		.rst(rst),
		.acc_valid(acc_valid),
		.acc(acc),
		.valid_out(valid_out),
		.res_out(res_out)
	);

endmodule

/* bench/conv_layer_props.sv */
module conv_layer_props #(
	parameter int relu_en = 1
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input logic valid_out,
	input conv_pkg::filt_pixels_t res_out
);
	import conv_pkg::*;

	logic any_negative;

	always_comb begin
		any_negative = 1'b0;
		for (int f = 0; f < num_filt; f++) begin
			any_negative = any_negative | res_out[f][pixel_w-1];
		end
	end

	assert property (@(posedge clk) disable iff (rst) !$isunknown(valid_out))
		else $error("valid_out is unknown after reset");

	// Decode, two MAC stages and the result register.
	assert property (@(posedge clk) disable iff (rst) valid_out |-> $past(valid_in, 4))
		else $error("valid_out without valid_in four cycles earlier");

	assert property (@(posedge clk) disable iff (rst)
		(relu_en != 0 && valid_out) |-> !any_negative)
		else $error("negative result with ReLU enabled");

endmodule

bind conv_layer_top conv_layer_props #(
	.relu_en(relu_en)
) props (
	.clk(clk),
	.rst(rst),
	.valid_in(valid_in),
	.valid_out(valid_out),
	.res_out(res_out)
);

/* bench/conv_layer_tb.sv */
module conv_layer_tb;
	import conv_pkg::*;

	localparam int img_w = 6;
	localparam int img_h = 6;
	localparam int win_stride = 1;
	localparam int rst_cycles = 10;
	localparam int latency = 4;
	localparam int frames = 2;
	localparam int gap_every = 5;
	localparam int gap_len = 3;
	// Header, 19 writes of 5 words, 36 pixels and 16 result lines.
	localparam int pat_depth = 3 + 19 * 5 + 36 * num_chan + 16 * num_filt;
	// Valid windows of one frame, no padding.
	localparam int frame_windows = ((img_w - kern_dim) / win_stride + 1)
		* ((img_h - kern_dim) / win_stride + 1);

	logic clk;
	logic rst;
	logic valid_in;
	chan_pixels_t pix_in;
	logic coef_we;
	logic coef_is_bias;
	logic [filt_sel_w-1:0] coef_filt;
	logic [chan_sel_w-1:0] coef_chan;
	logic [tap_sel_w-1:0] coef_tap;
	coef_t coef_data;
	logic valid_out;
	filt_pixels_t res_out;

	logic [15:0] pat [pat_depth];
	int num_coef;
	int num_pix;
	int num_exp;
	int pix_base;
	int exp_base;
	int cycle = 0;
	int seen = 0;
	bit pat_ready = 1'b0;
	int launch_q [$];

	conv_layer_top uut (
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.pix_in(pix_in),
		.coef_we(coef_we),
		.coef_is_bias(coef_is_bias),
		.coef_filt(coef_filt),
		.coef_chan(coef_chan),
		.coef_tap(coef_tap),
		.coef_data(coef_data),
		.valid_out(valid_out),
		.res_out(res_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] want);
		stop_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, want));
	endtask

	task automatic check_idle();
		assert (valid_out === 1'b0)
			else report_mismatch("valid_out", 16'(valid_out), 16'(0));
		for (int f = 0; f < num_filt; f++) begin
			assert (res_out[f] === '0)
				else report_mismatch($sformatf("res_out[%0d]", f), res_out[f], '0);
		end
	endtask

	task automatic read_patterns();
		$readmemh("bench/conv_patterns.mem", pat);
		num_coef = int'(pat[0]);
		num_pix = int'(pat[1]);
		num_exp = int'(pat[2]);
		pix_base = 3 + num_coef * 5;
		exp_base = pix_base + num_pix * num_chan;
		assert (exp_base + num_exp * num_filt == pat_depth)
			else stop_run("Pattern file section lengths do not match its size.");
		assert (num_pix == img_w * img_h)
			else stop_run("Pattern file does not hold exactly one frame of pixels.");
		assert (num_exp == frame_windows)
			else stop_run("Pattern file result count does not match the windows of a frame.");
		pat_ready = 1'b1;
	endtask

	task automatic write_coefs();
		int b;
		for (int i = 0; i < num_coef; i++) begin
			b = 3 + i * 5;
			@(posedge clk);
			check_idle();
			coef_we <= 1'b1;
			coef_is_bias <= pat[b][0];
			coef_filt <= pat[b+1][filt_sel_w-1:0];
			coef_chan <= pat[b+2][chan_sel_w-1:0];
			coef_tap <= pat[b+3][tap_sel_w-1:0];
			coef_data <= pat[b+4];
		end
		@(posedge clk);
		check_idle();
		coef_we <= 1'b0;
	endtask

	task automatic stream_frame();
		chan_pixels_t pix;
		int row;
		int col;
		for (int p = 0; p < num_pix; p++) begin
			row = p / img_w;
			col = p % img_w;
			for (int ch = 0; ch < num_chan; ch++) begin
				pix[ch] = pat[pix_base + p * num_chan + ch];
			end
			@(posedge clk);
			valid_in <= 1'b1;
			pix_in <= pix;
			// The DUT samples this pixel on the next edge.
			if (row >= 2 && col >= 2 && (row - 2) % win_stride == 0
					&& (col - 2) % win_stride == 0) begin
				launch_q.push_back(cycle + 1);
			end
			if ((p + 1) % gap_every == 0) begin
				repeat (gap_len) begin
					@(posedge clk);
					valid_in <= 1'b0;
				end
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		valid_in = 1'b0;
		pix_in = '0;
		coef_we = 1'b0;
		coef_is_bias = 1'b0;
		coef_filt = '0;
		coef_chan = '0;
		coef_tap = '0;
		coef_data = '0;
		read_patterns();
		for (int k = 0; k < rst_cycles; k++) begin
			@(posedge clk);
			if (k > 0) begin
				check_idle();
			end
		end
		rst <= 1'b0;
		write_coefs();
		// Frames back to back, same data.
		for (int fr = 0; fr < frames; fr++) begin
			stream_frame();
		end
		@(posedge clk);
		valid_in <= 1'b0;
		wait (seen == frames * num_exp);
		// Stray pulses after the last result.
		repeat (2 * latency) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

	always @(posedge clk) begin
		int launched;
		int e;
		if (!rst && valid_out) begin
			assert (seen < frames * num_exp)
				else stop_run("valid_out pulsed more often than the frames have windows.");
			assert (launch_q.size() > 0)
				else stop_run("valid_out pulsed with no completed window pending.");
			launched = launch_q.pop_front();
			assert (cycle - launched == latency)
				else report_mismatch("valid_out latency", 16'(cycle - launched), 16'(latency));
			e = exp_base + (seen % num_exp) * num_filt;
			for (int f = 0; f < num_filt; f++) begin
				assert (res_out[f] === pat[e + f])
					else report_mismatch($sformatf("res_out[%0d]", f), res_out[f], pat[e + f]);
			end
			seen <= seen + 1;
		end
	end

	initial begin
		int limit;
		wait (pat_ready);
		limit = rst_cycles + num_coef + 1
			+ frames * (num_pix + (num_pix / gap_every) * gap_len)
			+ 2 * latency + 50;
		repeat (limit) @(posedge clk);
		stop_run($sformatf("Timeout after %0d cycles, %0d of %0d results seen.",
			limit, seen, frames * num_exp));
	end

endmodule

/* bench/conv_patterns.mem */
// Header: number of coefficient writes, pixel lines, expected lines (hex).
// Write: flag (1 = bias), filter, channel, tap, value. Pixel: channels 0 to 5.
// Expected: filters 0 to 7, windows in raster order.
0013 0024 0010
1 0 0 0 0005
0 0 0 0 0001
1 1 0 0 ff9c
0 1 1 4 0002
1 2 0 0 0532
0 2 5 8 ffff
1 3 0 0 001e
0 3 2 2 0003
0 3 3 6 fffe
1 4 0 0 0000
0 4 4 5 001f
1 5 0 0 fff9
0 5 0 3 fffc
0 5 1 1 0005
1 6 0 0 0064
0 6 3 7 fffd
1 7 0 0 ffff
0 7 5 0 0100
0 7 0 8 ff00
// Pixel value is channel, row, column in hex digits.
0000 0100 0200 0300 0400 0500
0001 0101 0201 0301 0401 0501
0002 0102 0202 0302 0402 0502
0003 0103 0203 0303 0403 0503
0004 0104 0204 0304 0404 0504
0005 0105 0205 0305 0405 0505
0010 0110 0210 0310 0410 0510
0011 0111 0211 0311 0411 0511
0012 0112 0212 0312 0412 0512
0013 0113 0213 0313 0413 0513
0014 0114 0214 0314 0414 0514
0015 0115 0215 0315 0415 0515
0020 0120 0220 0320 0420 0520
0021 0121 0221 0321 0421 0521
0022 0122 0222 0322 0422 0522
0023 0123 0223 0323 0423 0523
0024 0124 0224 0324 0424 0524
0025 0125 0225 0325 0425 0525
0030 0130 0230 0330 0430 0530
0031 0131 0231 0331 0431 0531
0032 0132 0232 0332 0432 0532
0033 0133 0233 0333 0433 0533
0034 0134 0234 0334 0434 0534
0035 0135 0235 0335 0435 0535
0040 0140 0240 0340 0440 0540
0041 0141 0241 0341 0441 0541
0042 0142 0242 0342 0442 0542
0043 0143 0243 0343 0443 0543
0044 0144 0244 0344 0444 0544
0045 0145 0245 0345 0445 0545
0050 0150 0250 0350 0450 0550
0051 0151 0251 0351 0451 0551
0052 0152 0252 0352 0452 0552
0053 0153 0253 0353 0453 0553
0054 0154 0254 0354 0454 0554
0055 0155 0255 0355 0455 0555
// Expected results.
0005 01be 0010 0000 7e2e 04be 0000 7fff
0006 01c0 000f 0000 7e4d 04bf 0000 7fff
0007 01c2 000e 0000 7e6c 04c0 0000 7fff
0008 01c4 000d 0000 7e8b 04c1 0000 7fff
0015 01de 0000 0000 7fff 04ce 0000 7fff
0016 01e0 0000 0000 7fff 04cf 0000 7fff
0017 01e2 0000 0000 7fff 04d0 0000 7fff
0018 01e4 0000 0000 7fff 04d1 0000 7fff
0025 01fe 0000 0004 7fff 04de 0000 7fff
0026 0200 0000 0005 7fff 04df 0000 7fff
0027 0202 0000 0006 7fff 04e0 0000 7fff
0028 0204 0000 0007 7fff 04e1 0000 7fff
0035 021e 0000 0014 7fff 04ee 0000 7fff
0036 0220 0000 0015 7fff 04ef 0000 7fff
0037 0222 0000 0016 7fff 04f0 0000 7fff
0038 0224 0000 0017 7fff 04f1 0000 7fff

/* files.f */
logic/conv_pkg.sv
logic/coef_if.sv
logic/window_decode.sv
logic/conv_mac.sv
logic/result_stage.sv
logic/conv_layer_top.sv
bench/conv_layer_props.sv
bench/conv_layer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= conv_layer_tb
FILE_LIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
